/* Makefile */
# Verilator build and run for the decode front end testbench

TOP       ?= tbDecode
LOG       ?= sim.log
SEED      ?= 1
BUILD     ?= obj_dir
FILELIST  ?= verilog.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0

SIM     = $(BUILD)/V$(TOP)
SOURCES = $(wildcard design/*.sv) $(wildcard testbench/*.sv) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# SEED only sets the Verilator runtime seed, the testbench seeds its own stimulus
run: $(SIM)
	-./$(SIM) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '*** TEST PASSED ***' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

/* design/deCanonicalize.sv */
// Opcode canonicalizer
// Expands 16- and 32-bit forms into the native 64-bit format without a clock
`timescale 1ns/100ps
`default_nettype none

module deCanonicalize (
    input  wire decodePkg::rawInst_u instIn,
    output decodePkg::canonInst_t    instOut
);

    logic isCompact;  // 16-bit form
    logic isShort;    // 32-bit form
    logic isImmForm;  // 32-bit I-type
    logic signExt;    // 32-bit imm takes its sign

    assign isCompact = !instIn.inst16.size;
    assign isShort   = !isCompact && !instIn.inst32.size[0];
    assign isImmForm = instIn.inst32.op[5];

    // Sign-extend for the high units, for an all-zero unit and operation
    // and for the signed compares. Other immediates zero-extend
    assign signExt = instIn.inst32.op[4]
                  || (instIn.inst32.op[4:0] == 5'b00000)
                  || (instIn.inst32.op == decodePkg::OpSlti)
                  || (instIn.inst32.op == decodePkg::OpSgti);

    always_comb
    begin
        instOut      = '0;
        instOut.size = 2'b11; // Everything leaves as 64-bit

        if (isCompact)
        begin
            instOut.op  = decodePkg::OpcodeMap(instIn.inst16.op); // Reserved maps to illegal
            instOut.rd  = instIn.inst16.rd;
            instOut.rs1 = instIn.inst16.rd;    // Two-address form with Rd also a source
            instOut.rs2 = instIn.inst16.rsImm; // Ignored by imm ops
            // Ignored by register ops
            instOut.imm = {{26{instIn.inst16.rsImm[5]}}, instIn.inst16.rsImm};
        end
        else if (isShort)
        begin
            instOut.op = instIn.inst32.op;
            instOut.rd = instIn.inst32.rd;
            if (isImmForm)
            begin
                instOut.rs1 = instIn.inst32.rd2Rs1;
                if (signExt)
                    instOut.imm = {{20{instIn.inst32.opnd.imm[11]}}, instIn.inst32.opnd.imm};
                else
                    instOut.imm = {20'h0, instIn.inst32.opnd.imm};
            end
            else
            begin
                instOut.rd2 = instIn.inst32.rd2Rs1;
                instOut.rs1 = instIn.inst32.opnd.regs.rs1;
                instOut.rs2 = instIn.inst32.opnd.regs.rs2;
                // No immediate in R-type
            end
        end
        else
        begin
            instOut = instIn.inst64; // Already native
        end
    end

endmodule

`default_nettype wire

/* design/deFieldDecode.sv */
// Field decoder
// Registers unit, operands, immediate and enables of a canonical instruction
`timescale 1ns/100ps
`default_nettype none

module deFieldDecode (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire decodePkg::canonInst_t canon,
    input  wire                      inValid,
    output logic                     inReady,
    output decodePkg::decodedInst_t  decoded,
    output logic                     decodedValid,
    input  wire                      decodedReady
);

    decodePkg::decodedInst_t decNext;
    logic                    opKnown;
    logic                    load;

    assign inReady = !decodedValid || decodedReady; // Empty or being taken
    assign load    = inValid && inReady;

    // Only the listed opcodes decode, the illegal marker included as unknown
    always_comb
    begin
        case (canon.op)
            decodePkg::OpAdd, decodePkg::OpSub,
            decodePkg::OpAddi, decodePkg::OpSubi,
            decodePkg::OpAndi, decodePkg::OpOri,
            decodePkg::OpSlti, decodePkg::OpSgti,
            decodePkg::OpJ, decodePkg::OpJal,
            decodePkg::OpSyscall: opKnown = 1'b1;
            default:              opKnown = 1'b0;
        endcase
    end

    always_comb
    begin
        decNext.unit  = canon.op[4:3];
        decNext.op    = canon.op[2:0];
        decNext.isImm = canon.op[5];
        decNext.rd    = canon.rd;
        decNext.rd2   = canon.rd2;
        decNext.rs1   = canon.rs1;
        decNext.rs2   = canon.rs2;
        decNext.imm   = canon.imm;
        decNext.readRs1En = opKnown && (canon.op != decodePkg::OpSyscall);
        decNext.readRs2En = opKnown && !canon.op[5];  // R-type only
        decNext.writeRdEn = opKnown && (!canon.op[4] || canon.op == decodePkg::OpJal);
        decNext.illegal   = !opKnown; // Enables already low
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            decodedValid <= 1'b0;
        else if (load)
            decodedValid <= 1'b1;
        else if (decodedReady)
            decodedValid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (load)
            decoded <= decNext; // Held while the consumer stalls
    end

endmodule

`default_nettype wire

/* design/deInstAlign.sv */
// Instruction aligner
// Collects fetch words into a halfword buffer and emits one left-justified instruction
`timescale 1ns/100ps
`default_nettype none

module deInstAlign #(
    parameter int BufDepth = 8 // Halfwords, 8 or more
) (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire [63:0]             fetchWord,
    input  wire                    fetchValid,
    output logic                   fetchReady,
    input  wire                    alignReady,
    output decodePkg::alignOut_t   alignOut
);

    localparam int CntW = $clog2(BufDepth + 1);

    logic [15:0]       hwBuf   [BufDepth]; // Index 0 is the oldest halfword
    logic [15:0]       bufNext [BufDepth];
    logic [CntW-1:0]   fillCnt;            // Valid halfwords in hwBuf
    logic [CntW-1:0]   fillNext;
    logic [CntW-1:0]   shiftCnt;           // Halfwords leaving this cycle
    logic [CntW-1:0]   remCnt;             // Halfwords left before the append
    logic [2:0]        needHw;             // Size of the head instruction
    logic [3:0][15:0]  fetchHw;            // [3] is the first halfword of the word
    logic [63:0]       instWord;
    logic              fetchAccept;
    logic              outFree;
    logic              take;
    logic              outValid;
    decodePkg::rawInst_u outInst;

    assign fetchHw     = fetchWord;
    assign fetchAccept = fetchValid && fetchReady;
    assign outFree     = !outValid || alignReady; // Output empty or draining now
    assign take        = outFree && (fillCnt >= CntW'(needHw));

    assign alignOut.valid = outValid;
    assign alignOut.inst  = outInst;

    // Size marker sits in the top bits of the head halfword
    always_comb
    begin
        if (!hwBuf[0][15])
            needHw = 3'd1;
        else if (!hwBuf[0][14])
            needHw = 3'd2;
        else
            needHw = 3'd4;
    end

    // Left-justify the head instruction, zero the unused tail
    always_comb
    begin
        instWord = {hwBuf[0], hwBuf[1], hwBuf[2], hwBuf[3]};
        if (needHw == 3'd1)
            instWord[47:0] = '0;
        else if (needHw == 3'd2)
            instWord[31:0] = '0;
    end

    // Shift out the taken halfwords, then append the new word behind the rest
    always_comb
    begin
        shiftCnt = take ? CntW'(needHw) : '0;
        remCnt   = fillCnt - shiftCnt;
        fillNext = remCnt + (fetchAccept ? CntW'(4) : '0);
        for (int i = 0; i < BufDepth; i++)
        begin
            if (i + int'(shiftCnt) < BufDepth)
                bufNext[i] = hwBuf[i + int'(shiftCnt)];
            else
                bufNext[i] = '0; // Past the end
            if (fetchAccept && i >= int'(remCnt) && i < int'(remCnt) + 4)
                bufNext[i] = fetchHw[3 - (i - int'(remCnt))];
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            fillCnt    <= '0;
            fetchReady <= 1'b0;
            outValid   <= 1'b0;
        end
        else
        begin
            fillCnt    <= fillNext;
            // Room for one more whole word
            fetchReady <= (fillNext <= CntW'(BufDepth - 4));
            if (take)
                outValid <= 1'b1;
            else if (alignReady)
                outValid <= 1'b0; // Taken with nothing behind it
        end
    end

    // Buffer and output payload
    always_ff @(posedge clk)
    begin
        hwBuf <= bufNext;
        if (take)
            outInst <= instWord;
    end

endmodule

`default_nettype wire

/* design/decodePkg.sv */
// Decode front end shared types
// Opcode constants, raw instruction views and the canonical and decoded forms
`default_nettype none

package decodePkg;

    // Canonical opcodes: bit 5 type, bits 4:3 unit, bits 2:0 operation
    localparam logic [5:0] OpAdd     = 6'h00; // Rd = Rs1 + Rs2
    localparam logic [5:0] OpSub     = 6'h01; // Rd = Rs1 - Rs2
    localparam logic [5:0] OpAddi    = 6'h20;
    localparam logic [5:0] OpSubi    = 6'h21;
    localparam logic [5:0] OpAndi    = 6'h28; // Logic unit, zero-extended imm
    localparam logic [5:0] OpOri     = 6'h29;
    localparam logic [5:0] OpSlti    = 6'h2A; // Signed compares
    localparam logic [5:0] OpSgti    = 6'h2B;
    localparam logic [5:0] OpJ       = 6'h10; // Jump unit
    localparam logic [5:0] OpJal     = 6'h11;
    localparam logic [5:0] OpSyscall = 6'h18; // System unit
    localparam logic [5:0] OpIllegal = 6'h3F; // Marker for undecodable input

    // Compact 16-bit opcodes, code 7 reserved
    localparam logic [2:0] Op16Add     = 3'd0;
    localparam logic [2:0] Op16Sub     = 3'd1;
    localparam logic [2:0] Op16Addi    = 3'd2;
    localparam logic [2:0] Op16Subi    = 3'd3;
    localparam logic [2:0] Op16Syscall = 3'd4;
    localparam logic [2:0] Op16J       = 3'd5;
    localparam logic [2:0] Op16Jal     = 3'd6;

    // 16-bit form, left-justified in the word
    typedef struct packed {
        logic        size;  // Clear for 16-bit
        logic [2:0]  op;
        logic [5:0]  rd;    // Also the first source
        logic [5:0]  rsImm; // Rs2 or signed 6-bit imm
        logic [47:0] pad;
    } inst16_t;

    // Low 12 bits of a 32-bit form: two registers or one immediate
    typedef union packed {
        struct packed {
            logic [5:0] rs1;
            logic [5:0] rs2;
        } regs;             // R-type
        logic [11:0] imm;   // I-type
    } inst32Opnd_u;

    typedef struct packed {
        logic [1:0]  size;   // 2'b10 for 32-bit
        logic [5:0]  op;
        logic [5:0]  rd;
        logic [5:0]  rd2Rs1; // Rd2 for R-type, Rs1 for I-type
        inst32Opnd_u opnd;
        logic [31:0] pad;
    } inst32_t;

    // Native 64-bit format
    typedef struct packed {
        logic [1:0]  size; // Always 2'b11 once canonical
        logic [5:0]  op;
        logic [5:0]  rd;
        logic [5:0]  rd2;
        logic [5:0]  rs1;
        logic [5:0]  rs2;
        logic [31:0] imm;
    } canonInst_t;

    // One fetched instruction seen through each size
    typedef union packed {
        inst16_t    inst16;
        inst32_t    inst32;
        canonInst_t inst64;
    } rawInst_u;

    typedef struct packed {
        logic     valid;
        rawInst_u inst;
    } alignOut_t;

    typedef struct packed {
        logic [1:0]  unit;
        logic [2:0]  op;
        logic        isImm;
        logic [5:0]  rd;
        logic [5:0]  rd2;
        logic [5:0]  rs1;
        logic [5:0]  rs2;
        logic [31:0] imm;
        logic        readRs1En;
        logic        readRs2En;
        logic        writeRdEn;
        logic        illegal;
    } decodedInst_t;

    // Compact opcode to canonical opcode
    function automatic logic [5:0] OpcodeMap(input logic [2:0] op16);
        case (op16)
            Op16Add:     return OpAdd;
            Op16Sub:     return OpSub;
            Op16Addi:    return OpAddi;
            Op16Subi:    return OpSubi;
            Op16Syscall: return OpSyscall;
            Op16J:       return OpJ;
            Op16Jal:     return OpJal;
            default:     return OpIllegal; // Reserved code
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/decodeTop.sv */
// Decode front end top
// Aligner feeding the canonicalizer and the registered field decoder
`timescale 1ns/100ps
`default_nettype none

module decodeTop #(
    parameter int BufDepth = 8 // Aligner buffer in halfwords
) (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire [63:0]               fetchWord,
    input  wire                      fetchValid,
    output logic                     fetchReady,
    output decodePkg::decodedInst_t  decoded,
    output logic                     decodedValid,
    input  wire                      decodedReady
);

    decodePkg::alignOut_t  alignOut;  // Registered aligner output
    decodePkg::canonInst_t canonInst; // Same cycle, native format
    logic                  alignReady;

    deInstAlign #(
        .BufDepth   (BufDepth)
    ) uAlign (
        .clk        (clk),
        .rstN       (rstN),
        .fetchWord  (fetchWord),
        .fetchValid (fetchValid),
        .fetchReady (fetchReady),
        .alignReady (alignReady),
        .alignOut   (alignOut)
    );

    // Pure logic between the two registers
    deCanonicalize uCanon (
        .instIn     (alignOut.inst),
        .instOut    (canonInst)
    );

    deFieldDecode uDecode (
        .clk          (clk),
        .rstN         (rstN),
        .canon        (canonInst),
        .inValid      (alignOut.valid),
        .inReady      (alignReady),  // Back-pressure into the aligner
        .decoded      (decoded),
        .decodedValid (decodedValid),
        .decodedReady (decodedReady)
    );

endmodule

`default_nettype wire

/* include/tbDecodeModel.svh */
// Reference model for the decode front end testbench
// Builds random instructions, packs them into fetch words and predicts each decoded result
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Opcodes that the decoder accepts
function automatic bit knownOp(input logic [5:0] op);
    return op inside {decodePkg::OpAdd, decodePkg::OpSub, decodePkg::OpAddi,
                      decodePkg::OpSubi, decodePkg::OpAndi, decodePkg::OpOri,
                      decodePkg::OpSlti, decodePkg::OpSgti, decodePkg::OpJ,
                      decodePkg::OpJal, decodePkg::OpSyscall};
endfunction

// Mostly legal opcodes with any 6-bit value now and then
function automatic logic [5:0] pickOp();
    logic [5:0] op;
    op = 6'($urandom);
    if ($urandom % 8 != 0)
    begin
        while (!knownOp(op))
            op = 6'($urandom);
    end
    return op;
endfunction

// Decoded form of one canonical instruction
function automatic decodePkg::decodedInst_t expectDecode(
    input logic [5:0] op, input logic [5:0] rd, input logic [5:0] rd2,
    input logic [5:0] rs1, input logic [5:0] rs2, input logic [31:0] imm);
    decodePkg::decodedInst_t d;
    bit ok;
    ok      = knownOp(op);
    d.unit  = op[4:3];
    d.op    = op[2:0];
    d.isImm = op[5];
    d.rd    = rd;
    d.rd2   = rd2;
    d.rs1   = rs1;
    d.rs2   = rs2;
    d.imm   = imm;
    d.readRs1En = ok && (op != decodePkg::OpSyscall);
    d.readRs2En = ok && !op[5];                                   // R-type
    d.writeRdEn = ok && (op[4:3] < 2'd2 || op == decodePkg::OpJal); // ALU, logic, JAL
    d.illegal   = !ok;
    return d;
endfunction

// One random instruction, left-justified, with its size in halfwords
task automatic genInst(output logic [63:0] word, output int nHw,
                       output decodePkg::decodedInst_t exp);
    logic [2:0]  op3;
    logic [5:0]  op;
    logic [5:0]  rd;
    logic [5:0]  f2;
    logic [5:0]  f3;
    logic [5:0]  f4;
    logic [31:0] imm32;
    bit          sExt;
    int          kind;
    kind = int'($urandom % 3);
    rd   = 6'($urandom);
    f2   = 6'($urandom);
    f3   = 6'($urandom);
    f4   = 6'($urandom);
    if (kind == 0)
    begin
        op3  = 3'($urandom); // Code 7 included
        word = {1'b0, op3, rd, f2, 48'h0};
        nHw  = 1;
        exp  = expectDecode(decodePkg::OpcodeMap(op3), rd, 6'h0, rd, f2, {{26{f2[5]}}, f2});
    end
    else if (kind == 1)
    begin
        op   = pickOp();
        word = {2'b10, op, rd, f2, f3, f4, 32'h0};
        nHw  = 2;
        if (op[5])
        begin
            // Signed for the jump and system units, for ADDI and for the compares
            sExt  = op[4:3] >= 2'd2 || op == decodePkg::OpAddi
                 || op == decodePkg::OpSlti || op == decodePkg::OpSgti;
            imm32 = sExt ? {{20{f3[5]}}, f3, f4} : {20'h0, f3, f4};
            exp   = expectDecode(op, rd, 6'h0, f2, 6'h0, imm32);
        end
        else
            exp = expectDecode(op, rd, f2, f3, f4, 32'h0);
    end
    else
    begin
        op    = pickOp();
        imm32 = $urandom;
        word  = {2'b11, op, rd, f2, f3, f4, imm32};
        nHw   = 4;
        exp   = expectDecode(op, rd, f2, f3, f4, imm32); // Native form passes unchanged
    end
endtask

// Instruction stream packed with no gaps and padded to whole words with more instructions
task automatic buildStream();
    logic [15:0]             hwQ[$];
    logic [63:0]             w;
    int                      n;
    int                      count;
    decodePkg::decodedInst_t e;
    count = 0;
    while (count < NumInst || hwQ.size() % 4 != 0)
    begin
        genInst(w, n, e);
        for (int i = 0; i < n; i++)
            hwQ.push_back(w[63 - 16 * i -: 16]);
        expQ.push_back(e);
        sizeQ.push_back(n);
        count++;
    end
    while (hwQ.size() > 0)
    begin
        for (int i = 3; i >= 0; i--)
            w[16 * i +: 16] = hwQ.pop_front(); // First halfword on top
        words.push_back(w);
    end
endtask

`endif

/* testbench/tbDecode.sv */
// Decode front end testbench
// Random mixed-size stream with fetch gaps and consumer stalls checked against a model
`timescale 1ns/100ps
`default_nettype none

module tbDecode;

    localparam int BufDepth      = 8;
    localparam int NumInst       = 2000;
    localparam int CyclesPerInst = 12;
    localparam int ResetCycles   = 16;
    localparam int CycleLimit    = NumInst * CyclesPerInst + ResetCycles;
    localparam int DrainCycles   = 20;

    logic                    clk;
    logic                    rstN;
    logic [63:0]             fetchWord;
    logic                    fetchValid;
    logic                    fetchReady;
    decodePkg::decodedInst_t decoded;
    logic                    decodedValid;
    logic                    decodedReady;

    logic [63:0]             words[$]; // Fetch words in send order
    decodePkg::decodedInst_t expQ[$];  // Expected results in order
    int                      sizeQ[$]; // Halfwords of each expected instruction

    int valueErrs  = 0;
    int otherErrs  = 0;
    int cycles     = 0;  // Rising edges so far
    int wIdx       = 0;  // Next word to send
    int hwIn       = 0;
    int hwOut      = 0;
    int nDone      = 0;
    int stallLeft  = 0;
    int acceptEdge = -1; // Edge that takes the first word
    int firstEdge  = -1; // Edge that raises the first decodedValid
    bit accepted   = 0;

    `include "tbDecodeModel.svh"

    decodeTop #(
        .BufDepth     (BufDepth)
    ) dut (
        .clk          (clk),
        .rstN         (rstN),
        .fetchWord    (fetchWord),
        .fetchValid   (fetchValid),
        .fetchReady   (fetchReady),
        .decoded      (decoded),
        .decodedValid (decodedValid),
        .decodedReady (decodedReady)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Cycle counter and stall limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles == CycleLimit)
        begin
            $display("Stall: %0d instructions still expected after %0d cycles",
                     expQ.size(), cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp)
        begin
            valueErrs++;
            $display("ERROR %0t %s got %0h expected %0h (instruction %0d)",
                     $time, name, got, exp, nDone);
        end
    endtask

    // Operand and opcode fields
    task automatic checkDecoded(input decodePkg::decodedInst_t got,
                                input decodePkg::decodedInst_t exp);
        compareField("decoded.unit", 32'(got.unit), 32'(exp.unit));
        compareField("decoded.op", 32'(got.op), 32'(exp.op));
        compareField("decoded.isImm", 32'(got.isImm), 32'(exp.isImm));
        compareField("decoded.rd", 32'(got.rd), 32'(exp.rd));
        compareField("decoded.rd2", 32'(got.rd2), 32'(exp.rd2));
        compareField("decoded.rs1", 32'(got.rs1), 32'(exp.rs1));
        compareField("decoded.rs2", 32'(got.rs2), 32'(exp.rs2));
        compareField("decoded.imm", got.imm, exp.imm);
    endtask

    // Bits are illegal, readRs1En, readRs2En, writeRdEn
    task automatic checkFlags(input logic [3:0] got, input logic [3:0] exp);
        compareField("decoded.illegal", 32'(got[3]), 32'(exp[3]));
        compareField("decoded.readRs1En", 32'(got[2]), 32'(exp[2]));
        compareField("decoded.readRs2En", 32'(got[1]), 32'(exp[1]));
        compareField("decoded.writeRdEn", 32'(got[0]), 32'(exp[0]));
    endtask

    // Each falling edge samples settled outputs before driving the next inputs
    task automatic stepCycle();
        decodePkg::decodedInst_t exp;
        if (accepted)
        begin
            fetchValid = 1'b0; // Word went in at the last rising edge
            accepted   = 1'b0;
        end
        if (wIdx > 0 && !fetchReady && hwIn - hwOut < BufDepth - 3)
        begin
            otherErrs++;
            $display("fetchReady low at %0t with only %0d halfwords in flight",
                     $time, hwIn - hwOut);
        end
        if (decodedValid && acceptEdge < 0)
        begin
            otherErrs++;
            $display("decodedValid high at %0t before any fetch word was taken", $time);
        end
        if (decodedValid && firstEdge < 0)
            firstEdge = cycles;

        // Consumer with random stalls of a few cycles
        if (stallLeft > 0)
        begin
            decodedReady = 1'b0;
            stallLeft--;
        end
        else if ($urandom % 8 == 0)
        begin
            decodedReady = 1'b0;
            stallLeft    = int'($urandom % 6);
        end
        else
            decodedReady = 1'b1;

        if (decodedValid && decodedReady)
        begin
            exp    = expQ.pop_front();
            hwOut += sizeQ.pop_front();
            checkDecoded(decoded, exp);
            checkFlags({decoded.illegal, decoded.readRs1En, decoded.readRs2En,
                        decoded.writeRdEn},
                       {exp.illegal, exp.readRs1En, exp.readRs2En, exp.writeRdEn});
            nDone++;
        end

        // Producer with random gaps that holds each word until taken
        if (!fetchValid && wIdx < words.size() && $urandom % 4 != 0)
        begin
            fetchValid = 1'b1;
            fetchWord  = words[wIdx];
        end
        if (fetchValid && fetchReady)
        begin
            accepted = 1'b1;
            wIdx++;
            hwIn += 4;
            if (acceptEdge < 0)
                acceptEdge = cycles + 1;
        end
    endtask

    initial
    begin
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(32'hc9022565));
        rstN         = 1'b0;
        fetchWord    = 64'h0;
        fetchValid   = 1'b0;
        decodedReady = 1'b0;
        buildStream();

        repeat (ResetCycles) @(negedge clk);
        compareField("decodedValid", 32'(decodedValid), 32'h0); // Still in reset
        compareField("fetchReady", 32'(fetchReady), 32'h0);
        rstN = 1'b1;

        while (expQ.size() > 0)
        begin
            @(negedge clk);
            stepCycle();
        end

        // Nothing may follow the last instruction
        fetchValid = 1'b0;
        repeat (DrainCycles)
        begin
            @(negedge clk);
            if (decodedValid)
            begin
                otherErrs++;
                $display("Extra instruction decoded at %0t after the stream ended", $time);
            end
            decodedReady = 1'b1;
        end

        // Empty-buffer start gives a result two edges after the word is taken
        if (firstEdge != acceptEdge + 2)
        begin
            otherErrs++;
            $display("First result came %0d cycles after its fetch word instead of 2",
                     firstEdge - acceptEdge);
        end

        $display("Summary: %0d instructions checked, %0d value errors, %0d other errors",
                 nDone, valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
design/decodePkg.sv
design/deInstAlign.sv
design/deCanonicalize.sv
design/deFieldDecode.sv
design/decodeTop.sv
testbench/tbDecode.sv
